// ==== cpu_alu.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_alu (
  input  wire logic [31:0]      a,
  input  wire logic [31:0]      b,
  input  cpu_pkg::alu_func_e    func,
  output logic [31:0]           y,
  output cpu_pkg::flags_t       flags
);

  import cpu_pkg::*;

  logic [32:0] sum;

  always_comb begin
    sum     = 33'd0;
    y       = 32'd0;
    flags.c = 1'b0;
    flags.v = 1'b0;
    case (func)
      alu_and: y = a & b;
      alu_or:  y = a | b;
      alu_add: begin
        sum     = {1'b0, a} + {1'b0, b};
        y       = sum[31:0];
        flags.c = sum[32];
        flags.v = (a[31] == b[31]) && (y[31] != a[31]);
      end
      alu_sub: begin
        sum     = {1'b0, a} + {1'b0, ~b} + 33'd1;
        y       = sum[31:0];
        flags.c = sum[32]; // set when no borrow
        flags.v = (a[31] != b[31]) && (y[31] != a[31]);
      end
      alu_xor: y = a ^ b;
      alu_shl: y = a << b[4:0];
      alu_shr: y = a >> b[4:0]; // logical
      alu_pass: y = b;
      default: y = 32'd0;
    endcase
    flags.n = y[31];
    flags.z = (y == 32'd0);
  end

endmodule

`default_nettype wire

// ==== cpu_asserts.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_asserts (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  cpu_pkg::state_e    state,
  input  wire logic [31:0]   pc,
  input  wire logic          write_out
);

  import cpu_pkg::*;

  logic err_allowed = 1'b0; // raised only for the illegal-opcode program
  int   fail_count  = 0;

  a_write_states: assert property (@(posedge clk) disable iff (!rst_n)
    write_out |-> (state inside {st_store, st_call1, st_call2}))
    else begin
      $error("write strobe outside store or call states");
      fail_count++;
    end

  a_pc_even: assert property (@(posedge clk) disable iff (!rst_n) !pc[0])
    else begin
      $error("pc is odd");
      fail_count++;
    end

  // first cycle out of reset
  a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !write_out)
    else begin
      $error("write strobe right after reset");
      fail_count++;
    end

  a_no_err: assert property (@(posedge clk) disable iff (!rst_n || err_allowed)
    state != st_err)
    else begin
      $error("control FSM entered err");
      fail_count++;
    end

endmodule

bind cpu_control cpu_asserts u_asserts (
  .clk(clk), .rst_n(rst_n), .state(state), .pc(pc), .write_out(write_out)
);

`default_nettype wire

// ==== cpu_control.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_control (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic [15:0]      data_in,
  input  cpu_pkg::decoded_t     dec_now,
  input  cpu_pkg::decoded_t     dec_held,
  input  wire logic [31:0]      alu_y,
  input  cpu_pkg::flags_t       alu_flags,
  input  wire logic [31:0]      rdata1,
  input  wire logic [31:0]      rdata2,
  output logic [15:0]           insn_now,
  output logic [15:0]           insn_held,
  output logic [31:0]           alu_a,
  output logic [31:0]           alu_b,
  output cpu_pkg::alu_func_e    alu_func,
  output logic [4:0]            raddr1,
  output logic [4:0]            raddr2,
  output logic [4:0]            waddr,
  output logic [31:0]           wdata,
  output logic                  wen,
  output logic [31:0]           addrbus,
  output logic [15:0]           data_out,
  output logic                  write_out,
  output logic [3:0]            ccr
);

  import cpu_pkg::*;

  state_e      state, state_next;
  logic [31:0] pc, pc_next;
  logic [31:0] sp, sp_next;
  logic [31:0] mar, mar_next;
  logic [31:0] ret_pc, ret_pc_next;
  logic [15:0] opcode, opcode_next;
  logic [15:0] data_out_next;
  flags_t      ccr_q, ccr_next;
  logic [31:0] pc_inc;
  logic [31:0] imm_sext;
  logic [31:0] mem_addr;
  logic        br_taken;

  assign insn_now  = data_in;
  assign insn_held = opcode;
  assign ccr       = ccr_q;
  assign pc_inc    = pc + 32'd2;
  assign imm_sext  = {{16{data_in[15]}}, data_in};
  assign mem_addr  = {data_in, mar[15:0]}; // high word arriving in memop2

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_fetch1w;
      pc       <= reset_pc;
      sp       <= reset_sp;
      mar      <= 32'd0;
      ret_pc   <= 32'd0;
      opcode   <= 16'd0;
      data_out <= 16'd0;
      ccr_q    <= '0;
    end else begin
      state    <= state_next;
      pc       <= pc_next;
      sp       <= sp_next;
      mar      <= mar_next;
      ret_pc   <= ret_pc_next;
      opcode   <= opcode_next;
      data_out <= data_out_next;
      ccr_q    <= ccr_next;
    end
  end

  // signed compare rules on ccr
  always_comb begin
    br_taken = 1'b0;
    case (dec_held.op)
      op_bra:  br_taken = 1'b1;
      op_beq:  br_taken = ccr_q.z;
      op_bne:  br_taken = !ccr_q.z;
      op_bgt:  br_taken = !(ccr_q.z || (ccr_q.n != ccr_q.v));
      op_bge:  br_taken = (ccr_q.n == ccr_q.v);
      op_ble:  br_taken = ccr_q.z || (ccr_q.n != ccr_q.v);
      op_blt:  br_taken = (ccr_q.n != ccr_q.v);
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    state_next    = state;
    pc_next       = pc;
    sp_next       = sp;
    mar_next      = mar;
    ret_pc_next   = ret_pc;
    opcode_next   = opcode;
    data_out_next = data_out;
    ccr_next      = ccr_q;
    alu_a         = 32'd0;
    alu_b         = 32'd0;
    alu_func      = alu_pass;
    raddr1        = 5'd0;
    raddr2        = 5'd0;
    waddr         = 5'd0;
    wdata         = 32'd0;
    wen           = 1'b0;
    addrbus       = pc;
    write_out     = 1'b0;
    case (state)
      st_fetch1w: state_next = st_fetch1;
      st_fetch1: begin
        opcode_next = data_in;
        pc_next     = pc_inc;
        case (dec_now.op)
          op_nop: state_next = st_fetch1w;
          op_rts: begin
            state_next = st_rtn1w;
            sp_next    = sp + 32'd2;
          end
          op_inc, op_dec: begin
            state_next = st_fetch1w;
            raddr1     = dec_now.rd; // register from the word just fetched
            alu_a      = rdata1;
            alu_b      = 32'd1;
            if (dec_now.op == op_inc) begin
              alu_func = alu_add;
            end else begin
              alu_func = alu_sub;
            end
            waddr = dec_now.rd;
            wdata = alu_y;
            wen   = 1'b1;
          end
          op_alu_rr, op_mov, op_cmp, op_alu_ri, op_ldi,
          op_bra, op_beq, op_bne, op_bgt, op_bge, op_ble, op_blt:
            state_next = st_fetch2w;
          op_ld, op_st, op_jmp, op_jsr, op_ldl: state_next = st_memop1w;
          default: begin
            state_next = st_err;
            pc_next    = pc;
          end
        endcase
      end
      st_fetch2w: state_next = st_fetch2;
      st_fetch2: begin
        state_next = st_fetch1w;
        pc_next    = pc_inc;
        case (dec_held.op)
          op_alu_rr: begin
            raddr1   = data_in[12:8];
            raddr2   = data_in[4:0];
            alu_a    = rdata1;
            alu_b    = rdata2;
            alu_func = dec_held.func;
            waddr    = dec_held.rd;
            wdata    = alu_y;
            wen      = 1'b1;
          end
          op_mov: begin
            raddr1 = data_in[12:8];
            waddr  = dec_held.rd;
            wdata  = rdata1;
            wen    = 1'b1;
          end
          op_cmp: begin
            raddr1   = dec_held.rd;
            raddr2   = data_in[12:8];
            alu_a    = rdata1;
            alu_b    = rdata2;
            alu_func = alu_sub;
            ccr_next = alu_flags;
          end
          op_alu_ri: begin
            raddr1   = dec_held.rd;
            alu_a    = rdata1;
            alu_b    = imm_sext;
            alu_func = dec_held.func;
            waddr    = dec_held.rd;
            wdata    = alu_y;
            wen      = 1'b1;
          end
          op_ldi: begin
            waddr = dec_held.rd;
            wdata = imm_sext;
            wen   = 1'b1;
          end
          op_bra, op_beq, op_bne, op_bgt, op_bge, op_ble, op_blt: begin
            if (br_taken) begin
              pc_next = pc_inc + imm_sext; // relative to word after offset
            end
          end
          default: state_next = st_err;
        endcase
      end
      st_memop1w: state_next = st_memop1;
      st_memop1: begin
        state_next     = st_memop2w;
        pc_next        = pc_inc;
        mar_next[15:0] = data_in; // low address word
      end
      st_memop2w: state_next = st_memop2;
      st_memop2: begin
        pc_next  = pc_inc;
        mar_next = mem_addr;
        case (dec_held.op)
          op_ld: begin
            state_next = st_load;
            addrbus    = mem_addr; // data returns in load
          end
          op_st: begin
            state_next    = st_store;
            raddr1        = dec_held.rd;
            data_out_next = rdata1[15:0];
          end
          op_jmp: begin
            state_next = st_fetch1w;
            pc_next    = mem_addr;
          end
          op_jsr: begin
            state_next    = st_call1;
            ret_pc_next   = pc_inc;
            data_out_next = pc_inc[31:16]; // high half pushed first
          end
          op_ldl: begin
            state_next = st_fetch1w;
            waddr      = dec_held.rd;
            wdata      = mem_addr;
            wen        = 1'b1;
          end
          default: state_next = st_err;
        endcase
      end
      st_load: begin
        state_next = st_fetch1w;
        waddr      = dec_held.rd;
        wdata      = {16'h0000, data_in};
        wen        = 1'b1;
      end
      st_store: begin
        state_next = st_fetch1w;
        addrbus    = mar;
        write_out  = 1'b1;
      end
      st_call1: begin
        state_next    = st_call2;
        addrbus       = sp;
        write_out     = 1'b1;
        sp_next       = sp - 32'd2;
        data_out_next = ret_pc[15:0];
      end
      st_call2: begin
        state_next = st_fetch1w;
        addrbus    = sp;
        write_out  = 1'b1;
        sp_next    = sp - 32'd2;
        pc_next    = mar; // subroutine entry
      end
      st_rtn1w: begin
        state_next = st_rtn1;
        addrbus    = sp;
      end
      st_rtn1: begin
        state_next = st_rtn2w;
        pc_next    = {pc[31:16], data_in};
        sp_next    = sp + 32'd2;
      end
      st_rtn2w: begin
        state_next = st_rtn2;
        addrbus    = sp;
      end
      st_rtn2: begin
        state_next = st_fetch1w;
        pc_next    = {data_in, pc[15:0]};
      end
      st_err: state_next = st_err; // halted
      default: state_next = st_err;
    endcase
  end

endmodule

`default_nettype wire

// ==== cpu_decode.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_decode (
  input  wire logic [15:0]       insn,
  output cpu_pkg::decoded_t      dec
);

  import cpu_pkg::*;

  fmt_e       fmt;
  logic [7:0] sub;

  assign fmt = fmt_e'(insn[15:14]);
  assign sub = insn[12:5];

  always_comb begin
    dec.func = alu_func_e'(insn[7:5]);
    dec.rd   = insn[4:0];
    dec.op   = op_illegal;
    case (fmt)
      fmt_f0: begin
        case (sub)
          8'h00: dec.op = op_nop;
          8'h01: dec.op = op_rts;
          8'h03: dec.op = op_inc;
          8'h04: dec.op = op_dec;
          default: dec.op = op_illegal; // rti not supported
        endcase
      end
      fmt_f1: begin
        casez (sub)
          8'b0000_0???: dec.op = op_alu_rr; // func in bits 7:5
          8'h10:        dec.op = op_mov;
          8'h11:        dec.op = op_cmp;
          default:      dec.op = op_illegal;
        endcase
      end
      fmt_f2: begin
        casez (sub)
          8'b0000_0???: dec.op = op_alu_ri;
          8'h10:        dec.op = op_ldi;
          8'h20:        dec.op = op_bra;
          8'h21:        dec.op = op_beq;
          8'h22:        dec.op = op_bne;
          8'h24:        dec.op = op_bgt;
          8'h25:        dec.op = op_bge;
          8'h26:        dec.op = op_ble;
          8'h27:        dec.op = op_blt;
          default:      dec.op = op_illegal;
        endcase
      end
      fmt_f3: begin
        case (sub)
          8'h11:   dec.op = op_ld;
          8'h14:   dec.op = op_st;
          8'h16:   dec.op = op_jmp;
          8'h17:   dec.op = op_jsr;
          8'h20:   dec.op = op_ldl;
          default: dec.op = op_illegal;
        endcase
      end
      default: dec.op = op_illegal;
    endcase
  end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam logic [31:0] reset_pc = 32'hff000000; // boot address
  localparam logic [31:0] reset_sp = 32'h0007ffff; // stack top

  // instruction format, bits 15:14
  typedef enum logic [1:0] {
    fmt_f0,
    fmt_f1,
    fmt_f2,
    fmt_f3
  } fmt_e;

  typedef enum logic [4:0] {
    op_nop, op_rts, op_inc, op_dec,
    op_alu_rr, op_mov, op_cmp,
    op_alu_ri, op_ldi,
    op_bra, op_beq, op_bne, op_bgt, op_bge, op_ble, op_blt,
    op_ld, op_st, op_jmp, op_jsr, op_ldl,
    op_illegal
  } op_e;

  // encoded in insn bits 7:5 for rr and ri forms
  typedef enum logic [2:0] {
    alu_and,
    alu_or,
    alu_add,
    alu_sub,
    alu_xor,
    alu_shl,
    alu_shr,
    alu_pass
  } alu_func_e;

  typedef enum logic [4:0] {
    st_fetch1w, st_fetch1,
    st_fetch2w, st_fetch2,
    st_memop1w, st_memop1,
    st_memop2w, st_memop2,
    st_load, st_store,
    st_call1, st_call2,
    st_rtn1w, st_rtn1,
    st_rtn2w, st_rtn2,
    st_err
  } state_e;

  typedef struct packed {
    op_e       op;
    alu_func_e func;
    logic [4:0] rd;
  } decoded_t;

  // same bit order as ccr
  typedef struct packed {
    logic c;
    logic n;
    logic v;
    logic z;
  } flags_t;

endpackage

`default_nettype wire

// ==== cpu_regfile.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_regfile (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [4:0]  raddr1,
  input  wire logic [4:0]  raddr2,
  input  wire logic [4:0]  waddr,
  input  wire logic [31:0] wdata,
  input  wire logic        wen,
  output logic [31:0]      rdata1,
  output logic [31:0]      rdata2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // async read, old value during a same-cycle write
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_top (
  input  wire logic        clk,
  input  wire logic        rst_n,
  output logic [31:0]      addrbus,
  input  wire logic [15:0] data_in,
  output logic [15:0]      data_out,
  output logic             write_out,
  output logic [3:0]       ccr
);

  import cpu_pkg::*;

  logic [15:0] insn_now, insn_held;
  decoded_t    dec_now, dec_held;
  logic [31:0] alu_a, alu_b, alu_y;
  alu_func_e   alu_func;
  flags_t      alu_flags;
  logic [4:0]  raddr1, raddr2, waddr;
  logic [31:0] wdata, rdata1, rdata2;
  logic        wen;

  cpu_control u_control (
    .clk(clk), .rst_n(rst_n), .data_in(data_in),
    .dec_now(dec_now), .dec_held(dec_held),
    .alu_y(alu_y), .alu_flags(alu_flags),
    .rdata1(rdata1), .rdata2(rdata2),
    .insn_now(insn_now), .insn_held(insn_held),
    .alu_a(alu_a), .alu_b(alu_b), .alu_func(alu_func),
    .raddr1(raddr1), .raddr2(raddr2), .waddr(waddr),
    .wdata(wdata), .wen(wen),
    .addrbus(addrbus), .data_out(data_out), .write_out(write_out), .ccr(ccr)
  );

  cpu_decode u_decode_now  (.insn(insn_now),  .dec(dec_now));  // raw word in fetch1
  cpu_decode u_decode_held (.insn(insn_held), .dec(dec_held)); // latched opcode

  cpu_alu u_alu (.a(alu_a), .b(alu_b), .func(alu_func), .y(alu_y), .flags(alu_flags));

  cpu_regfile u_regfile (
    .clk(clk), .rst_n(rst_n),
    .raddr1(raddr1), .raddr2(raddr2), .waddr(waddr),
    .wdata(wdata), .wen(wen),
    .rdata1(rdata1), .rdata2(rdata2)
  );

endmodule

`default_nettype wire

// ==== list.f ====
cpu_pkg.sv
cpu_decode.sv
cpu_alu.sv
cpu_regfile.sv
cpu_control.sv
cpu_top.sv
cpu_asserts.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_cpu;

  import cpu_pkg::*;

  localparam int          clk_period         = 20;
  localparam int          n_programs         = 5;
  localparam int          cycles_per_program = 2000;
  localparam logic [31:0] res_addr           = 32'h00003000;
  localparam logic [31:0] done_addr          = 32'h00003002;
  localparam logic [31:0] data_addr          = 32'h00001000;
  localparam logic [7:0]  br_sub [7] = '{8'h20, 8'h21, 8'h22, 8'h24, 8'h25, 8'h26, 8'h27};

  logic        clk;
  logic        rst_n;
  logic [31:0] addrbus;
  logic [15:0] data_in = 16'h0000;
  logic [15:0] data_out;
  logic        write_out;
  logic [3:0]  ccr;

  logic [15:0] mem [65536];
  logic [31:0] a_q = 32'd0;
  logic [15:0] d_q = 16'd0;
  logic        w_q = 1'b0;
  logic [47:0] got_q [$]; // {address, data} of each store
  logic [47:0] exp_q [$];
  logic        done = 1'b0;
  logic [31:0] here;
  logic [31:0] sp_model;
  logic [3:0]  ccr_model;
  integer      seed;

  cpu_top UUT (
    .clk(clk), .rst_n(rst_n), .addrbus(addrbus), .data_in(data_in),
    .data_out(data_out), .write_out(write_out), .ccr(ccr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // bus sampled mid-cycle, answered after the next edge
  always @(negedge clk) begin
    a_q = addrbus;
    d_q = data_out;
    w_q = write_out;
  end

  always @(posedge clk) begin
    data_in <= #1 mem[a_q[16:1]];
    if (w_q === 1'b1) begin
      mem[a_q[16:1]] = d_q;
      if (a_q == done_addr) done = 1'b1;
      else got_q.push_back({a_q, d_q});
    end
  end

  task automatic report_mismatch(input string name, input logic [47:0] exp,
                                 input logic [47:0] act);
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    $display("TEST FAILED");
    $fatal(1, "%s mismatch", name);
  endtask

  function automatic logic [15:0] enc(input logic [1:0] fmt, input logic [7:0] sub,
                                      input logic [4:0] rd);
    return {fmt, 1'b0, sub, rd};
  endfunction

  function automatic logic [31:0] alu_ref(input int f, input logic [31:0] a,
                                          input logic [31:0] b);
    case (f)
      0: return a & b;
      1: return a | b;
      2: return a + b;
      3: return a - b;
      4: return a ^ b;
      5: return a << b[4:0];
      6: return a >> b[4:0];
      default: return b; // pass
    endcase
  endfunction

  // {c, n, v, z} left by cmp a, b
  function automatic logic [3:0] cmp_flags(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] diff;
    logic        c;
    logic        n;
    logic        v;
    diff = a - b;
    n    = diff[31];
    c    = (a >= b); // no borrow
    v    = n ^ ($signed(a) < $signed(b)); // lt is n != v
    return {c, n, v, (diff == 32'd0)};
  endfunction

  task automatic put(input logic [15:0] w);
    mem[here[16:1]] = w;
    here = here + 32'd2;
  endtask

  task automatic imm_form(input logic [15:0] w, input logic [15:0] x);
    put(w);
    put(x);
  endtask

  task automatic addr_form(input logic [15:0] w, input logic [31:0] a);
    put(w);
    put(a[15:0]); // low word first
    put(a[31:16]);
  endtask

  task automatic ldi(input logic [4:0] rd, input logic [15:0] imm);
    imm_form(enc(2'd2, 8'h10, rd), imm);
  endtask

  task automatic ldl(input logic [4:0] rd, input logic [31:0] v);
    addr_form(enc(2'd3, 8'h20, rd), v);
  endtask

  task automatic mov(input logic [4:0] rd, input logic [4:0] rs);
    imm_form(enc(2'd1, 8'h10, rd), {3'b000, rs, 8'h00});
  endtask

  task automatic store_low(input logic [4:0] rd, input logic [15:0] exp);
    addr_form(enc(2'd3, 8'h14, rd), res_addr);
    exp_q.push_back({res_addr, exp});
  endtask

  // high half goes out through r31
  task automatic store_word(input logic [4:0] rd, input logic [31:0] exp);
    store_low(rd, exp[15:0]);
    mov(5'd31, rd);
    imm_form(enc(2'd2, {5'd0, alu_shr}, 5'd31), 16'd16);
    store_low(5'd31, exp[31:16]);
  endtask

  task automatic finish_program();
    addr_form(enc(2'd3, 8'h14, 5'd0), done_addr);
    imm_form(enc(2'd2, 8'h20, 5'd0), 16'hfffc); // spin in place
  endtask

  task automatic begin_program();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    for (int i = 0; i < 65536; i++) mem[i] = 16'h0000;
    got_q.delete();
    exp_q.delete();
    done      = 1'b0;
    here      = reset_pc;
    sp_model  = reset_sp;
    ccr_model = 4'h0;
  endtask

  task automatic release_reset(input string name);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (addrbus == reset_pc)
      else report_mismatch({name, " boot fetch"}, {16'h0, reset_pc}, {16'h0, addrbus});
  endtask

  task automatic check_stores(input string name);
    assert (got_q.size() == exp_q.size())
      else report_mismatch({name, " store count"}, 48'(exp_q.size()), 48'(got_q.size()));
    for (int i = 0; i < exp_q.size(); i++) begin
      assert (got_q[i] == exp_q[i])
        else report_mismatch($sformatf("%s store %0d", name, i), exp_q[i], got_q[i]);
    end
  endtask

  task automatic run_program(input string name);
    release_reset(name);
    while (done !== 1'b1) @(posedge clk);
    repeat (2) @(posedge clk);
    check_stores(name);
    @(negedge clk);
    assert (ccr == ccr_model)
      else report_mismatch({name, " ccr"}, {44'h0, ccr_model}, {44'h0, ccr});
  endtask

  task automatic call(input logic [31:0] target);
    logic [31:0] ret;
    ret = here + 32'd6;
    exp_q.push_back({sp_model, ret[31:16]});
    exp_q.push_back({sp_model - 32'd2, ret[15:0]});
    sp_model = sp_model - 32'd4;
    addr_form(enc(2'd3, 8'h17, 5'd0), target);
  endtask

  task automatic alu_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [15:0] imm;
    begin_program();
    a = $random(seed);
    b = $random(seed);
    ldl(5'd1, a);
    ldl(5'd2, b);
    store_word(5'd1, a);
    for (int f = 0; f < 8; f++) begin
      imm_form(enc(2'd1, 8'(f), 5'd3), {3'b000, 5'd1, 3'b000, 5'd2});
      store_word(5'd3, alu_ref(f, a, b));
    end
    for (int f = 0; f < 8; f++) begin
      imm = $random(seed);
      mov(5'd4, 5'd1);
      imm_form(enc(2'd2, 8'(f), 5'd4), imm);
      store_word(5'd4, alu_ref(f, a, {{16{imm[15]}}, imm}));
    end
    imm = $random(seed);
    ldi(5'd5, imm);
    store_word(5'd5, {{16{imm[15]}}, imm});
    mov(5'd6, 5'd1);
    put(enc(2'd0, 8'h03, 5'd6)); // inc
    store_word(5'd6, a + 32'd1);
    mov(5'd7, 5'd2);
    put(enc(2'd0, 8'h04, 5'd7)); // dec
    store_word(5'd7, b - 32'd1);
    finish_program();
    run_program("alu");
  endtask

  task automatic branch_test();
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
    logic [15:0] t_val;
    logic [15:0] n_val;
    begin_program();
    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 7; k++) begin
        a = $random(seed);
        b = (r == 2) ? a : $random(seed);
        case (k)
          0: taken = 1'b1;
          1: taken = (a == b);
          2: taken = (a != b);
          3: taken = ($signed(a) > $signed(b));
          4: taken = ($signed(a) >= $signed(b));
          5: taken = ($signed(a) <= $signed(b));
          default: taken = ($signed(a) < $signed(b));
        endcase
        ccr_model = cmp_flags(a, b);
        t_val = 16'h0100 + 16'(r * 8 + k);
        n_val = 16'h0200 + 16'(r * 8 + k);
        ldl(5'd1, a);
        ldl(5'd2, b);
        ldi(5'd3, t_val);
        imm_form(enc(2'd1, 8'h11, 5'd1), {3'b000, 5'd2, 8'h00}); // cmp r1, r2
        imm_form(enc(2'd2, br_sub[k], 5'd0), 16'd4); // over one ldi
        ldi(5'd3, n_val);
        store_low(5'd3, taken ? t_val : n_val);
      end
    end
    finish_program();
    run_program("branch");
  endtask

  task automatic memory_test();
    logic [15:0] w;
    logic [31:0] v;
    logic [31:0] target;
    begin_program();
    w     = $random(seed);
    w[15] = 1'b1; // top bit set so zero extension shows
    v     = $random(seed);
    mem[data_addr[16:1]] = w;
    addr_form(enc(2'd3, 8'h11, 5'd8), data_addr); // ld r8
    store_word(5'd8, {16'h0000, w});
    ldl(5'd12, v);
    store_word(5'd12, v);
    ldi(5'd9, 16'h0055);
    target = here + 32'd10;
    addr_form(enc(2'd3, 8'h16, 5'd0), target); // jmp
    ldi(5'd9, 16'h00aa);
    store_low(5'd9, 16'h0055);
    finish_program();
    run_program("memory");
  endtask

  task automatic call_test();
    logic [31:0] sub1;
    logic [31:0] sub2;
    begin_program();
    sub1 = reset_pc + 32'h100;
    sub2 = reset_pc + 32'h200;
    call(sub1);
    here = sub1;
    call(sub2);
    here = sub2;
    ldi(5'd10, 16'h0001);
    store_low(5'd10, 16'h0001);
    put(enc(2'd0, 8'h01, 5'd0)); // rts
    here = sub1 + 32'd6;
    ldi(5'd10, 16'h0002);
    store_low(5'd10, 16'h0002);
    put(enc(2'd0, 8'h01, 5'd0));
    here = reset_pc + 32'd6;
    ldi(5'd10, 16'h0003);
    store_low(5'd10, 16'h0003);
    finish_program();
    run_program("call");
  endtask

  task automatic illegal_test();
    logic [31:0] halt_at;
    begin_program();
    UUT.u_control.u_asserts.err_allowed = 1'b1;
    ldi(5'd11, 16'h0077);
    store_low(5'd11, 16'h0077);
    halt_at = here;
    put(enc(2'd0, 8'hff, 5'd0)); // unused F0 code
    addr_form(enc(2'd3, 8'h14, 5'd11), res_addr);
    release_reset("illegal");
    while (got_q.size() < 1) @(posedge clk);
    repeat (4) @(posedge clk);
    for (int i = 0; i < 30; i++) begin
      @(negedge clk);
      assert (addrbus == halt_at && write_out == 1'b0)
        else report_mismatch("illegal halt", {16'h0, halt_at}, {15'h0, write_out, addrbus});
    end
    check_stores("illegal");
  endtask

  initial begin
    wait (UUT.u_control.u_asserts.fail_count != 0);
    $display("a bound assertion on the control FSM failed");
    $display("TEST FAILED");
    $fatal(1, "assertion failure");
  end

  initial begin
    #(n_programs * cycles_per_program * clk_period);
    $display("watchdog: programs did not finish in %0d cycles", n_programs * cycles_per_program);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    rst_n = 1'b0;
    seed  = 32'h68b6019e;
    alu_test();
    branch_test();
    memory_test();
    call_test();
    illegal_test();
    if (UUT.u_control.u_asserts.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire
